// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - sp_ram.sv
      - tag_lookup.sv
      - cache_ctrl.sv
      - burst_port.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_model.sv
      - tb_dcache.sv

// File: burst_port.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module burst_port
(
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::state_t     state,
    input  logic [`ADDR_W-1:0]    req_addr,
    input  cache_pkg::tag_t       victim_tag,
    input  cache_pkg::word_t      rdata,
    input  cache_pkg::cbus_resp_t cresp,
    output cache_pkg::cbus_req_t  creq,
    output cache_pkg::offset_t    beat,
    output logic                  beat_done,
    output logic                  burst_done
);

    localparam int LINE_LSB = `OFFSET_W + `BYTE_W;

    logic               in_burst;
    logic [`ADDR_W-1:0] line_addr;
    logic [`ADDR_W-1:0] victim_addr;

    assign in_burst = (state == cache_pkg::WRITEBACK) || (state == cache_pkg::FETCH);

    // both bursts start on the line boundary
    assign line_addr   = {req_addr[`ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
    assign victim_addr = {victim_tag, req_addr[LINE_LSB +: `INDEX_W], {LINE_LSB{1'b0}}};

    assign creq.valid    = in_burst;
    assign creq.is_write = (state == cache_pkg::WRITEBACK);
    assign creq.addr     = (state == cache_pkg::WRITEBACK) ? victim_addr : line_addr;
    assign creq.data     = rdata;              // ram word at current beat

    assign beat_done  = in_burst && cresp.ready;
    assign burst_done = beat_done && cresp.last;

    always_ff @(posedge clk)
    begin
        if (!reset)
            beat <= '0;
        else if (burst_done)
            beat <= '0;
        else if (beat_done)
            beat <= beat + 1'b1;
    end

endmodule

// File: cache_ctrl.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module cache_ctrl
(
    input  logic                 clk,
    input  logic                 reset,
    input  cache_pkg::dbus_req_t dreq,
    input  cache_pkg::lookup_t   result,
    input  logic                 beat_done,
    input  logic                 burst_done,
    input  cache_pkg::word_t     fill_data,
    output cache_pkg::state_t    state,
    output logic                 touch,
    output logic                 addr_ok,
    output logic                 data_ok,
    output logic                 data_wr,
    output cache_pkg::strobe_t   data_strobe,
    output cache_pkg::word_t     data_wdata,
    output logic                 meta_wr,
    output logic [`WAYS-1:0]     meta_strobe,
    output cache_pkg::meta_set_t meta_wdata,
    output cache_pkg::index_t    meta_index,
    output logic                 way
);

    localparam int INDEX_LSB = `OFFSET_W + `BYTE_W;
    localparam int TAG_LSB   = INDEX_LSB + `INDEX_W;

    cache_pkg::state_t state_nxt;
    cache_pkg::index_t req_index;
    cache_pkg::tag_t   req_tag;
    cache_pkg::index_t walk_idx;
    cache_pkg::meta_t  meta_new;
    logic              walking;
    logic              miss_way;
    logic              accept;
    logic              miss;
    logic              hit_write;

    assign req_index = dreq.addr[INDEX_LSB +: `INDEX_W];
    assign req_tag   = dreq.addr[TAG_LSB +: `TAG_W];

    assign addr_ok   = (state == cache_pkg::IDLE) && !walking;
    assign accept    = dreq.valid && addr_ok;
    assign miss      = accept && !result.hit;
    assign data_ok   = accept && result.hit;
    assign touch     = data_ok;
    assign hit_write = data_ok && (|dreq.strobe);

    assign way        = (state == cache_pkg::IDLE) ? result.way : miss_way;
    assign meta_index = walking ? walk_idx : req_index;

    // high from the first reset edge until one cycle after release
    always_ff @(posedge clk)
    begin
        if (!reset)
            walking <= 1'b1;
        else
            walking <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (walking)
            walk_idx <= walk_idx + 1'b1;
        else
            walk_idx <= '0;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            cache_pkg::IDLE:
            begin
                if (miss)
                    state_nxt = result.victim_dirty ? cache_pkg::WRITEBACK : cache_pkg::FETCH;
            end
            cache_pkg::WRITEBACK:
            begin
                if (burst_done)
                    state_nxt = cache_pkg::FETCH;
            end
            cache_pkg::FETCH:
            begin
                if (burst_done)
                    state_nxt = cache_pkg::IDLE;
            end
            default:
                state_nxt = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state    <= cache_pkg::IDLE;
            miss_way <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (miss)
                miss_way <= result.way;  // held for the whole miss
        end
    end

    always_comb
    begin
        data_wr     = 1'b0;
        data_strobe = '0;
        data_wdata  = dreq.data;
        if (hit_write)
        begin
            data_wr     = 1'b1;
            data_strobe = dreq.strobe;
        end
        else if (state == cache_pkg::FETCH && beat_done)
        begin
            data_wr     = 1'b1;
            data_strobe = '1;
            data_wdata  = fill_data;
        end
    end

    always_comb
    begin
        meta_wr     = 1'b0;
        meta_strobe = 2'b10 >> way;    // way 0 is the upper lane
        meta_new    = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
        if (walking)
        begin
            meta_wr     = 1'b1;
            meta_strobe = '1;
            meta_new    = '0;
        end
        else if (hit_write)
            meta_wr = 1'b1;
        else if (burst_done && state == cache_pkg::WRITEBACK)
        begin
            meta_wr  = 1'b1;
            meta_new = '0;
        end
        else if (burst_done && state == cache_pkg::FETCH)
        begin
            meta_wr        = 1'b1;
            meta_new.dirty = 1'b0;     // fresh line is clean
        end
        meta_wdata = {`WAYS{meta_new}};
    end

endmodule

// File: cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cache geometry
`define ADDR_W      32
`define WORD_W      64
`define SETS        8
`define WAYS        2
`define LINE_WORDS  16

// address split from the lsb up is byte then offset then index then tag
`define BYTE_W      3
`define OFFSET_W    4
`define INDEX_W     3
`define TAG_W       (`ADDR_W - `INDEX_W - `OFFSET_W - `BYTE_W)

`endif

// File: cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`TAG_W-1:0]    tag_t;
    typedef logic [`INDEX_W-1:0]  index_t;
    typedef logic [`OFFSET_W-1:0] offset_t;
    typedef logic [`WORD_W-1:0]   word_t;
    typedef logic [`WORD_W/8-1:0] strobe_t;

    typedef struct packed
    {
        logic valid;
        logic dirty;
        tag_t tag;
    } meta_t;

    // way 0 in the upper lane
    typedef meta_t [0:`WAYS-1] meta_set_t;

    typedef struct packed
    {
        logic               valid;
        logic [`ADDR_W-1:0] addr;
        strobe_t            strobe;  // nonzero means write
        word_t              data;
    } dbus_req_t;

    typedef struct packed
    {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    typedef struct packed
    {
        logic               valid;
        logic               is_write;
        logic [`ADDR_W-1:0] addr;
        word_t              data;
    } cbus_req_t;

    typedef struct packed
    {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    typedef struct packed
    {
        logic hit;
        logic way;           // hit way, or victim on a miss
        logic victim_dirty;
        tag_t victim_tag;
    } lookup_t;

    typedef enum logic [1:0]
    {
        IDLE,
        WRITEBACK,
        FETCH
    } state_t;

endpackage

// File: compile.f
+incdir+.
cache_pkg.sv
sp_ram.sv
tag_lookup.sv
cache_ctrl.sv
burst_port.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// File: dcache_top.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module dcache_top
(
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::dbus_req_t  dreq,
    output cache_pkg::dbus_resp_t dresp,
    output cache_pkg::cbus_req_t  creq,
    input  cache_pkg::cbus_resp_t cresp
);

    localparam int DATA_DEPTH = `SETS * `WAYS * `LINE_WORDS;

    cache_pkg::state_t             state;
    cache_pkg::lookup_t            result;
    cache_pkg::offset_t            beat;
    cache_pkg::offset_t            word_sel;
    cache_pkg::strobe_t            data_strobe;
    cache_pkg::word_t              data_wdata;
    cache_pkg::word_t              data_rdata;
    cache_pkg::meta_set_t          meta_wdata;
    cache_pkg::meta_set_t          meta_rdata;
    cache_pkg::index_t             meta_index;
    logic [$clog2(DATA_DEPTH)-1:0] data_addr;
    logic [`WAYS-1:0]              meta_strobe;
    logic                          touch;
    logic                          addr_ok;
    logic                          data_ok;
    logic                          data_wr;
    logic                          meta_wr;
    logic                          way;
    logic                          beat_done;
    logic                          burst_done;

    // request word on a hit, burst beat during a miss
    assign word_sel  = (state == cache_pkg::IDLE) ? dreq.addr[`BYTE_W +: `OFFSET_W] : beat;
    assign data_addr = {meta_index, way, word_sel};

    assign dresp = '{addr_ok: addr_ok, data_ok: data_ok, data: data_rdata};

    cache_ctrl ctrl_i (
        .clk(clk), .reset(reset), .dreq(dreq), .result(result),
        .beat_done(beat_done), .burst_done(burst_done), .fill_data(cresp.data),
        .state(state), .touch(touch), .addr_ok(addr_ok), .data_ok(data_ok),
        .data_wr(data_wr), .data_strobe(data_strobe), .data_wdata(data_wdata),
        .meta_wr(meta_wr), .meta_strobe(meta_strobe), .meta_wdata(meta_wdata),
        .meta_index(meta_index), .way(way)
    );

    tag_lookup lookup_i (
        .clk(clk), .reset(reset), .req_tag(dreq.addr[`ADDR_W-1 -: `TAG_W]),
        .index(meta_index), .meta(meta_rdata), .touch(touch), .result(result)
    );

    burst_port port_i (
        .clk(clk), .reset(reset), .state(state), .req_addr(dreq.addr),
        .victim_tag(result.victim_tag), .rdata(data_rdata), .cresp(cresp),
        .creq(creq), .beat(beat), .beat_done(beat_done), .burst_done(burst_done)
    );

    sp_ram #(.data_t(cache_pkg::word_t), .LANES($bits(cache_pkg::strobe_t)),
             .DEPTH(DATA_DEPTH)) data_ram (
        .clk(clk), .en(data_wr), .addr(data_addr), .strobe(data_strobe),
        .wdata(data_wdata), .rdata(data_rdata)
    );

    sp_ram #(.data_t(cache_pkg::meta_set_t), .LANES(`WAYS), .DEPTH(`SETS)) meta_ram (
        .clk(clk), .en(meta_wr), .addr(meta_index), .strobe(meta_strobe),
        .wdata(meta_wdata), .rdata(meta_rdata)
    );

endmodule

// File: sp_ram.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module sp_ram
#(
    parameter type data_t = logic [`WORD_W-1:0],
    parameter int  LANES  = `WORD_W / 8,
    parameter int  DEPTH  = `SETS * `WAYS * `LINE_WORDS
)
(
    input  logic                     clk,
    input  logic                     en,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [LANES-1:0]         strobe,
    input  data_t                    wdata,
    output data_t                    rdata
);

    localparam int WIDTH  = $bits(data_t);
    localparam int LANE_W = WIDTH / LANES;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [WIDTH-1:0] wbits;

    assign wbits = wdata;
    assign rdata = data_t'(mem[addr]);  // async read

    always_ff @(posedge clk)
    begin
        if (en)
        begin
            for (int i = 0; i < LANES; i++)
            begin
                if (strobe[i])
                    mem[addr][i*LANE_W +: LANE_W] <= wbits[i*LANE_W +: LANE_W];
            end
        end
    end

endmodule

// File: tag_lookup.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module tag_lookup
(
    input  logic                 clk,
    input  logic                 reset,
    input  cache_pkg::tag_t      req_tag,
    input  cache_pkg::index_t    index,
    input  cache_pkg::meta_set_t meta,
    input  logic                 touch,
    output cache_pkg::lookup_t   result
);

    logic [`SETS-1:0] last_used;   // way touched last, per set
    logic [`WAYS-1:0] match;
    logic             sel_way;

    always_comb
    begin
        for (int w = 0; w < `WAYS; w++)
            match[w] = meta[w].valid && (meta[w].tag == req_tag);
    end

    // hit way first, then an empty way, then the older one
    always_comb
    begin
        if (match[1])
            sel_way = 1'b1;
        else if (match[0])
            sel_way = 1'b0;
        else if (!meta[0].valid)
            sel_way = 1'b0;
        else if (!meta[1].valid)
            sel_way = 1'b1;
        else
            sel_way = ~last_used[index];
    end

    assign result.hit          = |match;
    assign result.way          = sel_way;
    assign result.victim_dirty = meta[sel_way].valid && meta[sel_way].dirty;
    assign result.victim_tag   = meta[sel_way].tag;

    always_ff @(posedge clk)
    begin
        if (!reset)
            last_used <= '0;
        else if (touch)
            last_used[index] <= sel_way;
    end

endmodule

// File: tb_dcache.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module tb_dcache;

    localparam int CLK_NS       = 10;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 16;
    localparam int RAND_SEED    = 94185;
    localparam int WADDR_W      = `ADDR_W - `BYTE_W;
    localparam int WATCHDOG_NS  = NUM_TESTS * 40 * 2 * CLK_NS + RESET_CYCLES * CLK_NS;
    localparam logic [`WORD_W-1:0] FILL_KEY = 64'h9e37_79b9_7f4a_7c15;

    localparam cache_pkg::tag_t TAG_A = 22'h01_2345;   // set 2
    localparam cache_pkg::tag_t TAG_B = 22'h3f_0001;   // set 5
    localparam cache_pkg::tag_t TAG_C = 22'h20_0002;
    localparam cache_pkg::tag_t TAG_D = 22'h00_0003;
    localparam cache_pkg::tag_t TAG_E = 22'h15_5555;   // set 0
    localparam cache_pkg::tag_t TAG_F = 22'h2a_aaaa;
    localparam cache_pkg::tag_t TAG_G = 22'h00_0fff;

    typedef struct packed
    {
        logic               is_write;
        logic [`ADDR_W-1:0] addr;
        cache_pkg::strobe_t strobe;
        cache_pkg::word_t   data;
        logic               expect_hit;  // data_ok in the acceptance cycle
    } test_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  bad_addr;
    cache_pkg::dbus_req_t  dreq;
    cache_pkg::dbus_resp_t dresp;
    cache_pkg::cbus_req_t  creq;
    cache_pkg::cbus_resp_t cresp;
    test_t                 tests [NUM_TESTS];
    cache_pkg::word_t      shadow [logic [WADDR_W-1:0]];

    always #(CLK_NS / 2) clk = ~clk;

    dcache_top dut_i (
        .clk(clk), .reset(reset), .dreq(dreq), .dresp(dresp), .creq(creq), .cresp(cresp)
    );

    tb_mem_model #(.SEED(RAND_SEED), .FILL_KEY(FILL_KEY)) mem_i (
        .clk(clk), .reset(reset), .creq(creq), .cresp(cresp), .bad_addr(bad_addr)
    );

    function automatic logic [`ADDR_W-1:0] make_addr(input cache_pkg::tag_t tag,
                                                     input cache_pkg::index_t index,
                                                     input cache_pkg::offset_t offset);
        return {tag, index, offset, {`BYTE_W{1'b0}}};
    endfunction

    function automatic cache_pkg::word_t expected_word(input logic [WADDR_W-1:0] waddr);
        if (shadow.exists(waddr))
            return shadow[waddr];
        return FILL_KEY ^ cache_pkg::word_t'(waddr);
    endfunction

    task automatic merge_write(input logic [WADDR_W-1:0] waddr, input cache_pkg::strobe_t strobe,
                               input cache_pkg::word_t data);
        cache_pkg::word_t w;
        w = expected_word(waddr);
        for (int b = 0; b < `WORD_W / 8; b++)
        begin
            if (strobe[b])
                w[b*8 +: 8] = data[b*8 +: 8];
        end
        shadow[waddr] = w;
    endtask

    task automatic compare(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("sim failed");
            $fatal(1, "stopped at the first failing check");
        end
    endtask

    task automatic expect_quiet();
        compare("creq.valid", creq.valid, 1'b0);
        compare("dresp.addr_ok", dresp.addr_ok, 1'b0);
        compare("dresp.data_ok", dresp.data_ok, 1'b0);
    endtask

    task automatic load_table();
        // set 2: read miss, same-line hits, partial write merge
        tests[0]  = '{1'b0, make_addr(TAG_A, 3'd2, 4'd3),  8'h00, 64'h0, 1'b0};
        tests[1]  = '{1'b0, make_addr(TAG_A, 3'd2, 4'd7),  8'h00, 64'h0, 1'b1};
        tests[2]  = '{1'b1, make_addr(TAG_A, 3'd2, 4'd5),  8'h0f, 64'h1122_3344_5566_7788, 1'b1};
        tests[3]  = '{1'b0, make_addr(TAG_A, 3'd2, 4'd5),  8'h00, 64'h0, 1'b1};
        // set 5: both ways dirty, way 0 touched last so way 1 goes
        tests[4]  = '{1'b1, make_addr(TAG_B, 3'd5, 4'd1),  8'hff, 64'hdead_beef_0bad_f00d, 1'b0};
        tests[5]  = '{1'b1, make_addr(TAG_C, 3'd5, 4'd2),  8'hf0, 64'ha1a2_a3a4_b1b2_b3b4, 1'b0};
        tests[6]  = '{1'b1, make_addr(TAG_B, 3'd5, 4'd9),  8'h3c, 64'h0123_4567_89ab_cdef, 1'b1};
        tests[7]  = '{1'b0, make_addr(TAG_D, 3'd5, 4'd0),  8'h00, 64'h0, 1'b0};
        tests[8]  = '{1'b0, make_addr(TAG_B, 3'd5, 4'd1),  8'h00, 64'h0, 1'b1};
        tests[9]  = '{1'b0, make_addr(TAG_C, 3'd5, 4'd2),  8'h00, 64'h0, 1'b0};  // from memory
        tests[10] = '{1'b0, make_addr(TAG_B, 3'd5, 4'd9),  8'h00, 64'h0, 1'b1};
        // set 0: dirty way 0 evicted by the third tag
        tests[11] = '{1'b1, make_addr(TAG_E, 3'd0, 4'd15), 8'h81, 64'hcafe_f00d_1234_5678, 1'b0};
        tests[12] = '{1'b0, make_addr(TAG_F, 3'd0, 4'd15), 8'h00, 64'h0, 1'b0};
        tests[13] = '{1'b0, make_addr(TAG_G, 3'd0, 4'd0),  8'h00, 64'h0, 1'b0};
        tests[14] = '{1'b0, make_addr(TAG_E, 3'd0, 4'd15), 8'h00, 64'h0, 1'b0};
        tests[15] = '{1'b0, make_addr(TAG_G, 3'd0, 4'd0),  8'h00, 64'h0, 1'b1};
    endtask

    task automatic run_test(input int num, input test_t t);
        int                 cycles;
        logic               got_ok;
        cache_pkg::word_t   rdata;
        logic [WADDR_W-1:0] waddr;
        cycles = 0;
        got_ok = 1'b0;
        rdata  = '0;
        waddr  = t.addr[`ADDR_W-1:`BYTE_W];
        @(negedge clk);
        dreq = '{valid: 1'b1, addr: t.addr, strobe: t.strobe, data: t.data};
        while (!got_ok)
        begin
            @(posedge clk);
            cycles++;
            got_ok = dresp.data_ok;   // pre-edge value
            rdata  = dresp.data;
        end
        compare($sformatf("dresp.data_ok at acceptance (entry %0d)", num), cycles == 1,
                t.expect_hit);
        if (t.is_write)
            merge_write(waddr, t.strobe, t.data);
        else
            compare($sformatf("dresp.data (entry %0d)", num), rdata, expected_word(waddr));
    endtask

    initial
    begin
        reset = 1'b0;
        load_table();
        // request held through reset, must not be taken
        dreq  = '{valid: 1'b1, addr: tests[0].addr, strobe: '0, data: '0};
        // state is unknown until the first edge
        for (int c = 0; c < RESET_CYCLES; c++)
        begin
            @(posedge clk);
            if (c > 0)
                expect_quiet();
        end
        @(negedge clk);
        reset = 1'b1;
        @(posedge clk);
        expect_quiet();     // metadata walk still running this cycle
        for (int i = 0; i < NUM_TESTS; i++)
            run_test(i, tests[i]);
        @(negedge clk);
        dreq = '0;
        $display("sim passed");
        $finish;
    end

    always @(negedge clk)
    begin
        if (bad_addr)
        begin
            $display("sim failed");
            $fatal(1, "memory model saw a burst that is not line aligned");
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog: a request did not complete within %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

// File: tb_mem_model.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module tb_mem_model
#(
    parameter int                 SEED     = 94185,
    parameter logic [`WORD_W-1:0] FILL_KEY = '0
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::cbus_req_t  creq,
    output cache_pkg::cbus_resp_t cresp,
    output logic                  bad_addr
);

    localparam int LINE_LSB = `OFFSET_W + `BYTE_W;
    localparam int WADDR_W  = `ADDR_W - `BYTE_W;

    cache_pkg::word_t   mem [logic [WADDR_W-1:0]];  // holds written-back words only
    cache_pkg::offset_t cnt;
    logic [WADDR_W-1:0] waddr;
    logic               ready;
    integer             seed;

    initial
    begin
        seed  = SEED;
        ready = 1'b0;
    end

    // untouched words follow the fill rule
    function automatic cache_pkg::word_t read_word(input logic [WADDR_W-1:0] a);
        if (mem.exists(a))
            return mem[a];
        return FILL_KEY ^ cache_pkg::word_t'(a);
    endfunction

    assign waddr = creq.addr[`ADDR_W-1:`BYTE_W] + cnt;

    always_comb
    begin
        cresp.ready = ready;
        cresp.last  = ready && (cnt == `LINE_WORDS - 1);
        cresp.data  = read_word(waddr);
    end

    // ready about half the time
    always @(negedge clk)
    begin
        logic [31:0] r;
        r = $random(seed);
        ready <= reset && r[0];
    end

    always @(posedge clk)
    begin
        if (!reset)
        begin
            cnt      <= '0;
            bad_addr <= 1'b0;
        end
        else if (creq.valid && ready)
        begin
            if (creq.addr[LINE_LSB-1:0] != '0)
            begin
                $display("memory model: burst address 0x%h is not line aligned", creq.addr);
                bad_addr <= 1'b1;
            end
            if (creq.is_write)
                mem[waddr] = creq.data;
            cnt <= cnt + 1'b1;  // wraps after the 16th beat
        end
    end

endmodule
